// File: dv/tb_bit_corr_tests.svh
// directed test tasks for the bit correlator, included inside the testbench module

////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////

// called 2 ns after a rising edge, returns the same way
task automatic send_beat(input corr_pkg::in_beat_t beat);
  logic done;
  done    = 1'b0;
  s_valid = 1'b1;
  s_data  = beat;
  while (!done) begin
    @(negedge clk);
    done = s_ready;
    @(posedge clk);
    #2;
  end
  s_valid = 1'b0;
endtask

task automatic wait_drain();
  m_ready = 1'b1;
  while (exp_q.size() != 0) begin
    @(posedge clk);
    #2;
  end
endtask

////////////////////////////////////////
// tests
////////////////////////////////////////

task automatic reset_state_test();
  @(negedge clk);
  check_value("m_valid", {79'd0, m_valid}, 80'd0);
  check_value("s_ready", {79'd0, s_ready}, 80'd1);
  @(posedge clk);
  #2;
endtask

// lane 2 gets a unit impulse, its outputs walk the pattern backwards
task automatic impulse_test();
  corr_pkg::in_beat_t  beat;
  corr_pkg::out_beat_t got;
  corr_pkg::acc_t      want;
  seen_q.delete();
  check_latency = 1'b1;
  m_ready       = 1'b1;
  beat          = '0;
  beat.samp[2]  = 16'sd1;
  send_beat(beat);
  beat = '0;
  repeat (8) send_beat(beat);
  wait_drain();
  check_latency = 1'b0;
  if (seen_q.size() != 9) begin
    report_failure($sformatf("impulse test saw %0d output beats instead of 9",
                             seen_q.size()));
  end else begin
    for (int i = 0; i < 9; i++) begin
      got = seen_q[i];
      if (i >= corr_pkg::CORR_LEN) begin
        want = '0;
      end else if (corr_pkg::CORR_TAPS[corr_pkg::CORR_LEN-1-i]) begin
        want = 20'sd1;
      end else begin
        want = -20'sd1;
      end
      for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
        check_value($sformatf("impulse beat %0d m_data.result[%0d]", i, l),
                    as_word(got.result[l]), (l == 2) ? as_word(want) : 80'd0);
      end
    end
  end
endtask

// back to back, s_ready must hold high the whole time
task automatic full_rate_test();
  check_latency = 1'b1;
  m_ready       = 1'b1;
  for (int i = 0; i < 64; i++) begin
    s_valid = 1'b1;
    s_data  = random_beat();
    @(negedge clk);
    check_value("s_ready", {79'd0, s_ready}, 80'd1);
    @(posedge clk);
    #2;
  end
  s_valid = 1'b0;
  wait_drain();
  check_latency = 1'b0;
endtask

// random stalls on both sides, the monitor checks stability and order
task automatic backpressure_test();
  int   sent;
  logic took;
  sent = 0;
  while (sent < 64) begin
    m_ready = random_bits(1) == 1;
    if (!s_valid && random_bits(2) != 0) begin
      s_valid = 1'b1;
      s_data  = random_beat();
    end
    @(negedge clk);
    took = s_valid && s_ready;
    @(posedge clk);
    #2;
    if (took) begin
      sent    = sent + 1;
      s_valid = 1'b0;
    end
  end
  wait_drain();
endtask

// full-scale negative then positive, largest sums the chain must hold
task automatic extremes_test();
  corr_pkg::in_beat_t beat;
  m_ready = 1'b1;
  for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
    beat.samp[l] = 16'h8000;
  end
  repeat (7) send_beat(beat);
  for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
    beat.samp[l] = 16'h7fff;
  end
  repeat (7) send_beat(beat);
  wait_drain();
endtask

// File: dv/tb_bit_corr.sv
// testbench top for the bit correlator: clock, reset, stimulus helpers, reference model, monitor
`timescale 1ns/1ps

module tb_bit_corr;

  ////////////////////////////////////////
  // run length
  ////////////////////////////////////////

  // beats sent by the directed tests, impulse + full rate + stall + extremes
  localparam int TOTAL_BEATS    = 9 + 64 + 64 + 14;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 200;

  logic                clk;
  logic                arst_n;
  logic                s_valid;
  logic                s_ready;
  corr_pkg::in_beat_t  s_data;
  logic                m_valid;
  logic                m_ready;
  corr_pkg::out_beat_t m_data;

  // model state and scoreboard
  int                  hist [corr_pkg::NUM_LANES][corr_pkg::CORR_LEN] = '{default: 0};
  corr_pkg::out_beat_t exp_q [$];
  int                  stamp_q [$];
  corr_pkg::out_beat_t seen_q [$];
  int                  cycle_cnt = 0;
  logic                check_latency = 1'b0;
  logic                stalled_q = 1'b0;
  corr_pkg::out_beat_t held_data;
  logic [31:0]         lfsr_state = 32'h9278;

  bit_corr_top uut (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // failure reporting and checks
  ////////////////////////////////////////

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [79:0] got,
                             input logic [79:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // zero-extended so sign handling never differs between the two sides
  function automatic logic [79:0] as_word(input corr_pkg::acc_t v);
    return {60'd0, v};
  endfunction

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic next_lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], next_lfsr_bit()};
    end
    return bits;
  endfunction

  function automatic corr_pkg::in_beat_t random_beat();
    corr_pkg::in_beat_t beat;
    logic [31:0]        r;
    for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
      r = random_bits(16);
      beat.samp[l] = r[15:0];
    end
    return beat;
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // hist[l][j] holds x[n-j]; y[n] sums s_k * x[n-6+k]
  task automatic model_accept(input corr_pkg::in_beat_t beat);
    corr_pkg::out_beat_t exp;
    int                  sum;
    for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
      for (int j = corr_pkg::CORR_LEN - 1; j > 0; j--) begin
        hist[l][j] = hist[l][j-1];
      end
      hist[l][0] = int'($signed(beat.samp[l]));
      sum = 0;
      for (int k = 0; k < corr_pkg::CORR_LEN; k++) begin
        if (corr_pkg::CORR_TAPS[k]) begin
          sum = sum + hist[l][corr_pkg::CORR_LEN-1-k];
        end else begin
          sum = sum - hist[l][corr_pkg::CORR_LEN-1-k];
        end
      end
      exp.result[l] = sum[corr_pkg::ACC_W-1:0];
    end
    exp_q.push_back(exp);
    stamp_q.push_back(cycle_cnt);
  endtask

  ////////////////////////////////////////
  // monitor and timeout
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout: run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
    end
  end

  // negedge sampling, all handshake signals are settled here
  always @(negedge clk) begin
    corr_pkg::out_beat_t exp;
    int                  stamp;
    if (arst_n) begin
      if (stalled_q) begin
        check_value("m_valid", {79'd0, m_valid}, 80'd1);
        check_value("m_data", m_data, held_data);
      end
      stalled_q = m_valid && !m_ready;
      held_data = m_data;
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("output beat appeared with no input beat behind it");
        end else begin
          exp   = exp_q.pop_front();
          stamp = stamp_q.pop_front();
          seen_q.push_back(m_data);
          for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
            check_value($sformatf("m_data.result[%0d]", l),
                        as_word(m_data.result[l]), as_word(exp.result[l]));
          end
          if (check_latency) begin
            check_value("accept-to-valid latency", 80'(cycle_cnt - stamp), 80'd2);
          end
        end
      end
      if (s_valid && s_ready) begin
        model_accept(s_data);
      end
    end
  end

  `include "tb_bit_corr_tests.svh"

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    arst_n  = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    m_ready = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;

    reset_state_test();
    impulse_test();
    full_rate_test();
    backpressure_test();
    extremes_test();
    wait_drain();

    // a duplicated beat would still be offered here
    if (exp_q.size() != 0 || m_valid !== 1'b0) begin
      report_failure("output stream still busy after the final drain");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the correlator testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

TOP=tb_bit_corr
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f sim.f -o "$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

if [ ! -x "obj_dir/$TOP" ]; then
  echo "simulation binary obj_dir/$TOP is missing"
  exit 1
fi

"./obj_dir/$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$SIM_LOG"; then
  echo "run passed"
  exit 0
else
  echo "pass line not found in $SIM_LOG"
  exit 1
fi

// File: sim.f
+incdir+dv
verilog/corr_pkg.sv
verilog/corr_frame_splitter.sv
verilog/corr_lane.sv
verilog/corr_result_merger.sv
verilog/bit_corr_top.sv
dv/tb_bit_corr.sv

// File: verilog/bit_corr_top.sv
// top level of the four-lane streaming bit correlator with valid/ready input and output
`timescale 1ns/1ps

module bit_corr_top (
  input  logic                clk,
  input  logic                arst_n,

  // input stream, one sample per lane
  input  logic                s_valid,
  output logic                s_ready,
  input  corr_pkg::in_beat_t  s_data,

  // output stream, one result per lane
  output logic                m_valid,
  input  logic                m_ready,
  output corr_pkg::out_beat_t m_data
);

  ////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////

  logic                step;
  logic                merge_free;
  corr_pkg::acc_t      lane_samp [corr_pkg::NUM_LANES];
  corr_pkg::out_beat_t lane_results;

  // input stage
  corr_frame_splitter u_splitter (
    .clk        (clk),
    .arst_n     (arst_n),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data),
    .merge_free (merge_free),
    .step       (step),
    .lane_samp  (lane_samp)
  );

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////

  genvar i;
  generate
    for (i = 0; i < corr_pkg::NUM_LANES; i = i + 1) begin : lane_gen
      corr_lane u_lane (
        .clk    (clk),
        .arst_n (arst_n),
        .step   (step),
        .samp   (lane_samp[i]),
        .result (lane_results.result[i])
      );
    end
  endgenerate

  // output stage
  corr_result_merger u_merger (
    .clk          (clk),
    .arst_n       (arst_n),
    .step         (step),
    .lane_results (lane_results),
    .merge_free   (merge_free),
    .m_valid      (m_valid),
    .m_ready      (m_ready),
    .m_data       (m_data)
  );

endmodule

// File: verilog/corr_frame_splitter.sv
// input stage of the correlator: takes one beat, sign-extends each lane and drives the lane step
`timescale 1ns/1ps

module corr_frame_splitter (
  input  logic                clk,
  input  logic                arst_n,

  // input stream
  input  logic                s_valid,
  output logic                s_ready,
  input  corr_pkg::in_beat_t  s_data,

  // from the merger
  input  logic                merge_free,

  // to the lanes
  output logic                step,
  output corr_pkg::acc_t      lane_samp [corr_pkg::NUM_LANES]
);

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////

  corr_pkg::in_beat_t stage_q;
  logic               full_q;
  logic               take;

  // stage moves on whenever it holds a beat and the output side has room
  assign step = full_q & merge_free;

  // empty stage, or one that drains this cycle, can take a new beat
  assign s_ready = ~full_q | step;

  assign take = s_valid & s_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (step) begin
      full_q <= 1'b0;
    end
  end

  // payload only, qualified by full_q
  always_ff @(posedge clk) begin
    if (take) begin
      stage_q <= s_data;
    end
  end

  ////////////////////////////////////////
  // sign extension per lane
  ////////////////////////////////////////

  genvar i;
  generate
    for (i = 0; i < corr_pkg::NUM_LANES; i = i + 1) begin : ext_gen
      assign lane_samp[i] = {
        {(corr_pkg::ACC_W - corr_pkg::SAMP_W){stage_q.samp[i][corr_pkg::SAMP_W-1]}},
        stage_q.samp[i]
      };
    end
  endgenerate

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // lanes must never advance on a stale or missing beat
  step_needs_beat: assert property (
    @(posedge clk) disable iff (!arst_n)
    (step && !take) |=> !step
  );

  // a stalled stage keeps its beat until the lanes consume it
  stage_holds: assert property (
    @(posedge clk) disable iff (!arst_n)
    (full_q && !step) |=> (full_q && $stable(stage_q))
  );

endmodule

// File: verilog/corr_lane.sv
// one correlator lane: transposed adder chain with fixed +1/-1 taps, advanced on each step
`timescale 1ns/1ps

module corr_lane (
  input  logic           clk,
  input  logic           arst_n,

  // advance strobe shared by all lanes
  input  logic           step,

  // sign-extended sample for this beat
  input  corr_pkg::acc_t samp,

  // correlation for the current sample
  output corr_pkg::acc_t result
);

  ////////////////////////////////////////
  // adder chain
  ////////////////////////////////////////

  corr_pkg::acc_t psum_q  [corr_pkg::CORR_LEN-1];
  corr_pkg::acc_t tap_in  [corr_pkg::CORR_LEN];
  corr_pkg::acc_t tap_out [corr_pkg::CORR_LEN];

  genvar k;
  generate
    for (k = 0; k < corr_pkg::CORR_LEN; k = k + 1) begin : tap_gen

      // tap 0 starts the chain from zero
      if (k == 0) begin : first
        assign tap_in[k] = '0;
      end else begin : rest
        assign tap_in[k] = psum_q[k-1];
      end

      // pattern bit picks add or subtract
      assign tap_out[k] = corr_pkg::CORR_TAPS[k] ? tap_in[k] + samp
                                                 : tap_in[k] - samp;

      // last tap goes straight to the merger
      if (k < corr_pkg::CORR_LEN - 1) begin : store
        always_ff @(posedge clk or negedge arst_n) begin
          if (!arst_n) begin
            psum_q[k] <= '0;
          end else if (step) begin
            psum_q[k] <= tap_out[k];
          end
        end
      end

    end
  endgenerate

  // last tap already sums all seven products for this sample
  assign result = tap_out[corr_pkg::CORR_LEN-1];

endmodule

// File: verilog/corr_pkg.sv
// shared constants and beat types for the bit correlator, referenced by scoped name
package corr_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  // parallel sample channels per beat
  localparam int NUM_LANES = 4;

  // input sample width
  localparam int SAMP_W = 16;

  // partial sum and result width
  // 16 bits plus 3 bits of growth for 7 taps, plus margin
  localparam int ACC_W = 20;

  // number of taps in the pattern
  localparam int CORR_LEN = 7;

  ////////////////////////////////////////
  // coefficient pattern
  ////////////////////////////////////////

  // bit k set means tap k adds the sample, clear means it subtracts
  localparam logic [CORR_LEN-1:0] CORR_TAPS = 7'b0110110;

  ////////////////////////////////////////
  // sample and sum types
  ////////////////////////////////////////

  typedef logic signed [SAMP_W-1:0] samp_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  ////////////////////////////////////////
  // stream beats
  ////////////////////////////////////////

  // one sample per lane, lane 0 in the low bits
  typedef struct packed {
    samp_t [NUM_LANES-1:0] samp;
  } in_beat_t;

  // one result per lane, lane 0 in the low bits
  typedef struct packed {
    acc_t [NUM_LANES-1:0] result;
  } out_beat_t;

endpackage

// File: verilog/corr_result_merger.sv
// output stage of the correlator: registers the packed lane results and holds them under back-pressure
`timescale 1ns/1ps

module corr_result_merger (
  input  logic                clk,
  input  logic                arst_n,

  // from the splitter and lanes
  input  logic                step,
  input  corr_pkg::out_beat_t lane_results,

  // back to the splitter
  output logic                merge_free,

  // output stream
  output logic                m_valid,
  input  logic                m_ready,
  output corr_pkg::out_beat_t m_data
);

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  logic                m_valid_q;
  corr_pkg::out_beat_t m_data_q;

  // room for a new beat if empty or draining now
  assign merge_free = ~m_valid_q | m_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid_q <= 1'b0;
    end else if (step) begin
      // new beat, covers the transfer-and-refill case too
      m_valid_q <= 1'b1;
    end else if (m_ready) begin
      m_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      m_data_q <= lane_results;
    end
  end

  assign m_valid = m_valid_q;
  assign m_data  = m_data_q;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // a stalled beat stays offered
  valid_held: assert property (
    @(posedge clk) disable iff (!arst_n)
    (m_valid && !m_ready) |=> m_valid
  );

  // and its payload does not move while stalled
  data_held: assert property (
    @(posedge clk) disable iff (!arst_n)
    (m_valid && !m_ready) |=> $stable(m_data)
  );

  // a stall upstream must also freeze the lanes
  no_step_when_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    (m_valid && !m_ready) |-> !step
  );

endmodule
